// ==== axil_soc_trace.txt ====
# pair master op addr wdata strb exp_rdata exp_resp backpressure (hex fields)
# pair 1 issues the line together with the next one, resp 0 is OKAY and 3 is DECERR
0 0 W a0000000 11223344 f 00000000 0 0
0 0 R a0000000 00000000 0 11223344 0 0
0 1 W a0001000 55667788 f 00000000 0 0
0 1 R a0001000 00000000 0 55667788 0 0
0 0 W a0002000 99aabbcc f 00000000 0 0
0 1 R a0002000 00000000 0 99aabbcc 0 0
# Partial strobe over a known word
0 1 W a0000004 deadbeef f 00000000 0 0
0 1 W a0000004 00a500c3 5 00000000 0 0
0 0 R a0000004 00000000 0 dea5bec3 0 0
# Unmapped space
0 0 R 90000000 00000000 0 00000000 3 0
0 1 W a0003000 ffffffff f 00000000 3 0
0 1 R a0003000 00000000 0 00000000 3 0
0 0 W 9ffffffc ffffffff f 00000000 3 0
0 0 R a0000000 00000000 0 11223344 0 0
# Both masters at once
1 0 R a0001000 00000000 0 55667788 0 0
0 1 W a0002004 01020304 f 00000000 0 0
1 0 W a0000008 cafef00d f 00000000 0 0
0 1 R a0000004 00000000 0 dea5bec3 0 0
1 0 R a0002004 00000000 0 01020304 0 0
0 1 R 80000000 00000000 0 00000000 3 0
0 1 R a0000008 00000000 0 cafef00d 0 0
# Random back-pressure on rready and bready
0 0 W a0000000 11223344 f 00000000 0 1
0 1 R a0000000 00000000 0 11223344 0 1
0 0 R a0001000 00000000 0 55667788 0 1
0 1 R a0002000 00000000 0 99aabbcc 0 1
1 0 W a0001000 55667788 f 00000000 0 1
0 1 R a0002000 00000000 0 99aabbcc 0 1

// ==== axil_soc.f ====
+incdir+.
axil_bus_pkg.sv
axil_map_pkg.sv
axil_if.sv
axil_arbiter.sv
axil_xbar.sv
axil_ram_slave.sv
axil_soc_top.sv
tb_clock_gen.sv
tb_axil_soc.sv

// ==== Bender.yml ====
package:
  name: axil_soc

sources:
  - include_dirs:
      - .
    files:
      - axil_bus_pkg.sv
      - axil_map_pkg.sv
      - axil_if.sv
      - axil_arbiter.sv
      - axil_xbar.sv
      - axil_ram_slave.sv
      - axil_soc_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_axil_soc.sv

// ==== tb_axil_soc.sv ====
`timescale 1ns/1ps

module tb_axil_soc;
    import axil_bus_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int DRIVE_DLY = 2;

    typedef struct packed {
        logic       pair;
        logic       m;
        logic       is_wr;
        axil_addr_t addr;
        axil_data_t wdata;
        axil_strb_t strb;
        axil_data_t exp_data;
        axil_resp_t exp_resp;
        logic       bp;
    } txn_t;

    logic       clk;
    logic       rst_n;
    axil_addr_t araddr  [2];
    logic       arvalid [2];
    logic       arready [2];
    axil_data_t rdata   [2];
    axil_resp_t rresp   [2];
    logic       rvalid  [2];
    logic       rready  [2];
    axil_addr_t awaddr  [2];
    logic       awvalid [2];
    logic       awready [2];
    axil_data_t wdata   [2];
    axil_strb_t wstrb   [2];
    logic       wvalid  [2];
    logic       wready  [2];
    axil_resp_t bresp   [2];
    logic       bvalid  [2];
    logic       bready  [2];
    txn_t       trace   [$];
    integer     seed = 32'hc116_3d23;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axil_soc_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .m0_araddr  (araddr[0]),
        .m0_arvalid (arvalid[0]),
        .m0_arready (arready[0]),
        .m0_rdata   (rdata[0]),
        .m0_rresp   (rresp[0]),
        .m0_rvalid  (rvalid[0]),
        .m0_rready  (rready[0]),
        .m0_awaddr  (awaddr[0]),
        .m0_awvalid (awvalid[0]),
        .m0_awready (awready[0]),
        .m0_wdata   (wdata[0]),
        .m0_wstrb   (wstrb[0]),
        .m0_wvalid  (wvalid[0]),
        .m0_wready  (wready[0]),
        .m0_bresp   (bresp[0]),
        .m0_bvalid  (bvalid[0]),
        .m0_bready  (bready[0]),
        .m1_araddr  (araddr[1]),
        .m1_arvalid (arvalid[1]),
        .m1_arready (arready[1]),
        .m1_rdata   (rdata[1]),
        .m1_rresp   (rresp[1]),
        .m1_rvalid  (rvalid[1]),
        .m1_rready  (rready[1]),
        .m1_awaddr  (awaddr[1]),
        .m1_awvalid (awvalid[1]),
        .m1_awready (awready[1]),
        .m1_wdata   (wdata[1]),
        .m1_wstrb   (wstrb[1]),
        .m1_wvalid  (wvalid[1]),
        .m1_wready  (wready[1]),
        .m1_bresp   (bresp[1]),
        .m1_bvalid  (bvalid[1]),
        .m1_bready  (bready[1])
    );

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input axil_data_t got, input axil_data_t exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // Nothing may be offered to a master that has not asked
    task automatic check_idle(input int m);
        string tag;
        tag = $sformatf("m%0d_", m);
        check_flag(arready[m], 1'b0, {tag, "arready"});
        check_flag(awready[m], 1'b0, {tag, "awready"});
        check_flag(wready[m], 1'b0, {tag, "wready"});
        check_flag(rvalid[m], 1'b0, {tag, "rvalid"});
        check_flag(bvalid[m], 1'b0, {tag, "bvalid"});
    endtask

    function automatic logic next_ready(input logic bp);
        if (!bp) begin
            return 1'b1;
        end
        return logic'($random(seed) & 1);
    endfunction

    task automatic load_trace();
        int         fd;
        int         n;
        int         m_f;
        string      line;
        byte        op;
        logic       pair_f;
        logic       bp_f;
        axil_addr_t addr_f;
        axil_data_t wdata_f;
        axil_strb_t strb_f;
        axil_data_t rdata_f;
        logic [1:0] resp_f;
        txn_t       t;
        fd = $fopen("axil_soc_trace.txt", "r");
        if (fd == 0) begin
            stop_run("Could not open the trace file axil_soc_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %c %h %h %h %h %h %h", pair_f, m_f, op, addr_f,
                        wdata_f, strb_f, rdata_f, resp_f, bp_f);
            if (n != 9 || m_f > 1 || (op != "R" && op != "W")) begin
                stop_run($sformatf("Trace line could not be understood: %s", line));
            end
            t.pair     = pair_f;
            t.m        = m_f[0];
            t.is_wr    = (op == "W");
            t.addr     = addr_f;
            t.wdata    = wdata_f;
            t.strb     = strb_f;
            t.exp_data = rdata_f;
            t.exp_resp = axil_resp_t'(resp_f);
            t.bp       = bp_f;
            trace.push_back(t);
        end
        $fclose(fd);
    endtask

    // Starts and ends a little after a rising edge
    task automatic do_read(input txn_t t);
        int    m;
        int    cycles;
        logic  hs;
        logic  done;
        string tag;
        m = t.m;
        tag = $sformatf("m%0d", m);
        araddr[m]  = t.addr;
        arvalid[m] = 1'b1;
        rready[m]  = next_ready(t.bp);
        cycles = 0;
        while (arvalid[m]) begin
            @(negedge clk);
            hs = arready[m];
            @(posedge clk);
            #DRIVE_DLY;
            if (hs) begin
                arvalid[m] = 1'b0;
            end
            rready[m] = next_ready(t.bp);
            cycles++;
            if (arvalid[m] && cycles >= TIMEOUT) begin
                stop_run($sformatf("Timeout: %s read address %h was never accepted", tag, t.addr));
            end
        end
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (rvalid[m]) begin
                check_data(rdata[m], t.exp_data, {tag, "_rdata"});
                check_resp(rresp[m], t.exp_resp, {tag, "_rresp"});
                done = rready[m];
            end
            @(posedge clk);
            #DRIVE_DLY;
            rready[m] = done ? 1'b0 : next_ready(t.bp);
            cycles++;
            if (!done && cycles >= TIMEOUT) begin
                stop_run($sformatf("Timeout: %s read response for %h never arrived", tag, t.addr));
            end
        end
    endtask

    task automatic do_write(input txn_t t);
        int    m;
        int    cycles;
        logic  aw_hs;
        logic  w_hs;
        logic  done;
        string tag;
        m = t.m;
        tag = $sformatf("m%0d", m);
        awaddr[m]  = t.addr;
        awvalid[m] = 1'b1;
        wdata[m]   = t.wdata;
        wstrb[m]   = t.strb;
        wvalid[m]  = 1'b1;
        bready[m]  = next_ready(t.bp);
        cycles = 0;
        while (awvalid[m] || wvalid[m]) begin
            @(negedge clk);
            aw_hs = awvalid[m] && awready[m];
            w_hs  = wvalid[m] && wready[m];
            @(posedge clk);
            #DRIVE_DLY;
            if (aw_hs) begin
                awvalid[m] = 1'b0;
            end
            if (w_hs) begin
                wvalid[m] = 1'b0;
            end
            bready[m] = next_ready(t.bp);
            cycles++;
            if ((awvalid[m] || wvalid[m]) && cycles >= TIMEOUT) begin
                stop_run($sformatf("Timeout: %s write to %h was never accepted", tag, t.addr));
            end
        end
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (bvalid[m]) begin
                check_resp(bresp[m], t.exp_resp, {tag, "_bresp"});
                done = bready[m];
            end
            @(posedge clk);
            #DRIVE_DLY;
            bready[m] = done ? 1'b0 : next_ready(t.bp);
            cycles++;
            if (!done && cycles >= TIMEOUT) begin
                stop_run($sformatf("Timeout: %s write response for %h never arrived", tag, t.addr));
            end
        end
    endtask

    task automatic run_txn(input txn_t t);
        if (t.is_wr) begin
            do_write(t);
        end else begin
            do_read(t);
        end
    endtask

    initial begin
        int i;
        int cycles;
        for (i = 0; i < 2; i++) begin
            araddr[i]  = '0;
            arvalid[i] = 1'b0;
            rready[i]  = 1'b0;
            awaddr[i]  = '0;
            awvalid[i] = 1'b0;
            wdata[i]   = '0;
            wstrb[i]   = '0;
            wvalid[i]  = 1'b0;
            bready[i]  = 1'b0;
        end
        load_trace();

        cycles = 0;
        while (!rst_n) begin
            @(negedge clk);
            check_idle(0);
            check_idle(1);
            cycles++;
            if (!rst_n && cycles >= TIMEOUT) begin
                stop_run("Timeout: reset was never released");
            end
        end
        // Still quiet with no request pending
        repeat (3) begin
            @(negedge clk);
            check_idle(0);
            check_idle(1);
        end
        @(posedge clk);
        #DRIVE_DLY;

        i = 0;
        while (i < trace.size()) begin
            if (trace[i].pair && i + 1 < trace.size()) begin
                fork
                    run_txn(trace[i]);
                    run_txn(trace[i + 1]);
                join
                i += 2;
            end else begin
                run_txn(trace[i]);
                i++;
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release 2 ns after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

// ==== axil_soc_top.sv ====
`timescale 1ns/1ps
`include "axil_soc_config.svh"

module axil_soc_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // Instruction fetch master
    input  axil_bus_pkg::axil_addr_t m0_araddr,
    input  logic                     m0_arvalid,
    output logic                     m0_arready,
    output axil_bus_pkg::axil_data_t m0_rdata,
    output axil_bus_pkg::axil_resp_t m0_rresp,
    output logic                     m0_rvalid,
    input  logic                     m0_rready,
    input  axil_bus_pkg::axil_addr_t m0_awaddr,
    input  logic                     m0_awvalid,
    output logic                     m0_awready,
    input  axil_bus_pkg::axil_data_t m0_wdata,
    input  axil_bus_pkg::axil_strb_t m0_wstrb,
    input  logic                     m0_wvalid,
    output logic                     m0_wready,
    output axil_bus_pkg::axil_resp_t m0_bresp,
    output logic                     m0_bvalid,
    input  logic                     m0_bready,
    // Load/store master
    input  axil_bus_pkg::axil_addr_t m1_araddr,
    input  logic                     m1_arvalid,
    output logic                     m1_arready,
    output axil_bus_pkg::axil_data_t m1_rdata,
    output axil_bus_pkg::axil_resp_t m1_rresp,
    output logic                     m1_rvalid,
    input  logic                     m1_rready,
    input  axil_bus_pkg::axil_addr_t m1_awaddr,
    input  logic                     m1_awvalid,
    output logic                     m1_awready,
    input  axil_bus_pkg::axil_data_t m1_wdata,
    input  axil_bus_pkg::axil_strb_t m1_wstrb,
    input  logic                     m1_wvalid,
    output logic                     m1_wready,
    output axil_bus_pkg::axil_resp_t m1_bresp,
    output logic                     m1_bvalid,
    input  logic                     m1_bready
);

    axil_if m0_bus ();
    axil_if m1_bus ();
    axil_if arb_bus ();
    axil_if slv_bus [`AXIL_NUM_SLAVES] ();

    assign m0_bus.araddr  = m0_araddr;
    assign m0_bus.arvalid = m0_arvalid;
    assign m0_arready     = m0_bus.arready;
    assign m0_rdata       = m0_bus.rdata;
    assign m0_rresp       = m0_bus.rresp;
    assign m0_rvalid      = m0_bus.rvalid;
    assign m0_bus.rready  = m0_rready;
    assign m0_bus.awaddr  = m0_awaddr;
    assign m0_bus.awvalid = m0_awvalid;
    assign m0_awready     = m0_bus.awready;
    assign m0_bus.wdata   = m0_wdata;
    assign m0_bus.wstrb   = m0_wstrb;
    assign m0_bus.wvalid  = m0_wvalid;
    assign m0_wready      = m0_bus.wready;
    assign m0_bresp       = m0_bus.bresp;
    assign m0_bvalid      = m0_bus.bvalid;
    assign m0_bus.bready  = m0_bready;

    assign m1_bus.araddr  = m1_araddr;
    assign m1_bus.arvalid = m1_arvalid;
    assign m1_arready     = m1_bus.arready;
    assign m1_rdata       = m1_bus.rdata;
    assign m1_rresp       = m1_bus.rresp;
    assign m1_rvalid      = m1_bus.rvalid;
    assign m1_bus.rready  = m1_rready;
    assign m1_bus.awaddr  = m1_awaddr;
    assign m1_bus.awvalid = m1_awvalid;
    assign m1_awready     = m1_bus.awready;
    assign m1_bus.wdata   = m1_wdata;
    assign m1_bus.wstrb   = m1_wstrb;
    assign m1_bus.wvalid  = m1_wvalid;
    assign m1_wready      = m1_bus.wready;
    assign m1_bresp       = m1_bus.bresp;
    assign m1_bvalid      = m1_bus.bvalid;
    assign m1_bus.bready  = m1_bready;

    axil_arbiter i_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .m0    (m0_bus),
        .m1    (m1_bus),
        .bus   (arb_bus)
    );

    axil_xbar i_xbar (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (arb_bus),
        .slv   (slv_bus)
    );

    // RAMs standing in for memory, UART and CLINT
    for (genvar i = 0; i < `AXIL_NUM_SLAVES; i++) begin : g_ram
        axil_ram_slave i_ram (
            .clk   (clk),
            .rst_n (rst_n),
            .bus   (slv_bus[i])
        );
    end

endmodule

// ==== axil_ram_slave.sv ====
`timescale 1ns/1ps
`include "axil_soc_config.svh"

module axil_ram_slave (
    input logic   clk,
    input logic   rst_n,
    axil_if.slave bus
);
    import axil_bus_pkg::*;

    localparam int DEPTH = `AXIL_RAM_WORDS;
    localparam int BYTES = `AXIL_DATA_W / 8;
    localparam int OFS   = $clog2(BYTES);
    localparam int IDX_W = $clog2(DEPTH);

    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_HAVE_AW, WR_HAVE_W, WR_RESP} wr_state_t;

    rd_state_t  rd_state;
    wr_state_t  wr_state;
    axil_data_t mem [DEPTH];
    axil_data_t rdata_q;
    axil_addr_t awaddr_q;
    axil_data_t wdata_q;
    axil_strb_t wstrb_q;
    logic       aw_hs;
    logic       w_hs;
    logic       wr_fire;
    axil_addr_t wr_addr;
    axil_data_t wr_data;
    axil_strb_t wr_strb;

    assign bus.arready = (rd_state == RD_IDLE);
    assign bus.rvalid  = (rd_state == RD_RESP);
    assign bus.rdata   = rdata_q;
    assign bus.rresp   = OKAY;
    assign bus.awready = (wr_state == WR_IDLE) || (wr_state == WR_HAVE_W);
    assign bus.wready  = (wr_state == WR_IDLE) || (wr_state == WR_HAVE_AW);
    assign bus.bvalid  = (wr_state == WR_RESP);
    assign bus.bresp   = OKAY;

    assign aw_hs = bus.awvalid && bus.awready;
    assign w_hs  = bus.wvalid && bus.wready;

    // Whichever beat arrives second completes the write
    assign wr_fire = (aw_hs || wr_state == WR_HAVE_AW) && (w_hs || wr_state == WR_HAVE_W);
    assign wr_addr = aw_hs ? bus.awaddr : awaddr_q;
    assign wr_data = w_hs ? bus.wdata : wdata_q;
    assign wr_strb = w_hs ? bus.wstrb : wstrb_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
        end else if (rd_state == RD_IDLE && bus.arvalid) begin
            rd_state <= RD_RESP;
        end else if (rd_state == RD_RESP && bus.rready) begin
            rd_state <= RD_IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_fire) begin
                        wr_state <= WR_RESP;
                    end else if (aw_hs) begin
                        wr_state <= WR_HAVE_AW;
                    end else if (w_hs) begin
                        wr_state <= WR_HAVE_W;
                    end
                end
                WR_HAVE_AW, WR_HAVE_W: begin
                    if (wr_fire) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (bus.bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arvalid && bus.arready) begin
            rdata_q <= mem[bus.araddr[IDX_W+OFS-1:OFS]];
        end
        if (aw_hs) begin
            awaddr_q <= bus.awaddr;
        end
        if (w_hs) begin
            wdata_q <= bus.wdata;
            wstrb_q <= bus.wstrb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr[IDX_W+OFS-1:OFS]][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== axil_xbar.sv ====
`timescale 1ns/1ps
`include "axil_soc_config.svh"

module axil_xbar (
    input logic    clk,
    input logic    rst_n,
    axil_if.slave  bus,
    axil_if.master slv [`AXIL_NUM_SLAVES]
);
    import axil_bus_pkg::*;
    import axil_map_pkg::*;

    localparam int N = `AXIL_NUM_SLAVES;

    typedef enum logic [1:0] {IDLE, ROUTE, ERR_RESP} state_t;

    state_t       state;
    decode_t      target;
    decode_t      dec;
    logic         err_rd;
    logic         miss_rd;
    logic         miss_wr;
    logic         done;
    logic [N-1:0] arready_s;
    logic [N-1:0] rvalid_s;
    logic [N-1:0] awready_s;
    logic [N-1:0] wready_s;
    logic [N-1:0] bvalid_s;
    logic [N-1:0] valid_s;
    axil_data_t   rdata_s [N];
    axil_resp_t   rresp_s [N];
    axil_resp_t   bresp_s [N];

    function automatic decode_t decode(input axil_addr_t addr);
        axil_addr_t offset;
        decode_t    d;
        offset = addr - `AXIL_SLAVE_BASE;
        d.hit  = (addr >= `AXIL_SLAVE_BASE) && (offset < N * `AXIL_SLAVE_SPAN);
        d.idx  = slave_idx_t'(offset / `AXIL_SLAVE_SPAN);
        return d;
    endfunction

    assign dec  = decode(bus.arvalid ? bus.araddr : bus.awaddr);
    assign done = (bus.rvalid && bus.rready) || (bus.bvalid && bus.bready);

    // Misses are accepted here and never reach a slave
    assign miss_rd = (state == IDLE) && bus.arvalid && !dec.hit;
    assign miss_wr = (state == IDLE) && !bus.arvalid && bus.awvalid && bus.wvalid && !dec.hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            target <= '0;
            err_rd <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (bus.arvalid || bus.awvalid) begin
                        target <= dec;
                        err_rd <= bus.arvalid;
                    end
                    if ((bus.arvalid || bus.awvalid) && dec.hit) begin
                        state <= ROUTE;
                    end else if (miss_rd || miss_wr) begin
                        state <= ERR_RESP;
                    end
                end
                ROUTE, ERR_RESP: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_slv
        logic sel;

        assign sel = (state == ROUTE) && target.hit && (target.idx == slave_idx_t'(i));

        // Unselected slaves see zeros
        assign slv[i].araddr  = sel ? bus.araddr : '0;
        assign slv[i].arvalid = sel && bus.arvalid;
        assign slv[i].rready  = sel && bus.rready;
        assign slv[i].awaddr  = sel ? bus.awaddr : '0;
        assign slv[i].awvalid = sel && bus.awvalid;
        assign slv[i].wdata   = sel ? bus.wdata : '0;
        assign slv[i].wstrb   = sel ? bus.wstrb : '0;
        assign slv[i].wvalid  = sel && bus.wvalid;
        assign slv[i].bready  = sel && bus.bready;

        assign arready_s[i] = slv[i].arready;
        assign rdata_s[i]   = slv[i].rdata;
        assign rresp_s[i]   = slv[i].rresp;
        assign rvalid_s[i]  = slv[i].rvalid;
        assign awready_s[i] = slv[i].awready;
        assign wready_s[i]  = slv[i].wready;
        assign bresp_s[i]   = slv[i].bresp;
        assign bvalid_s[i]  = slv[i].bvalid;
        assign valid_s[i]   = slv[i].arvalid | slv[i].awvalid | slv[i].wvalid |
                              slv[i].rvalid | slv[i].bvalid;
    end

    always_comb begin
        bus.arready = miss_rd;
        bus.awready = miss_wr;
        bus.wready  = miss_wr;
        bus.rdata   = '0;
        bus.rresp   = OKAY;
        bus.rvalid  = 1'b0;
        bus.bresp   = OKAY;
        bus.bvalid  = 1'b0;
        case (state)
            ROUTE: begin
                bus.arready = arready_s[target.idx];
                bus.rdata   = rdata_s[target.idx];
                bus.rresp   = rresp_s[target.idx];
                bus.rvalid  = rvalid_s[target.idx];
                bus.awready = awready_s[target.idx];
                bus.wready  = wready_s[target.idx];
                bus.bresp   = bresp_s[target.idx];
                bus.bvalid  = bvalid_s[target.idx];
            end
            ERR_RESP: begin
                bus.rresp  = DECERR;
                bus.rvalid = err_rd;
                bus.bresp  = DECERR;
                bus.bvalid = !err_rd;
            end
            default: begin
            end
        endcase
    end

    // Requests and responses live on one slave at a time
    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(valid_s));

    // Routed responses hold under back-pressure
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata) && $stable(bus.rresp));
    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bresp));

endmodule

// ==== axil_arbiter.sv ====
`timescale 1ns/1ps

module axil_arbiter (
    input logic    clk,
    input logic    rst_n,
    axil_if.slave  m0,
    axil_if.slave  m1,
    axil_if.master bus
);

    typedef enum logic {IDLE, GRANT} state_t;

    state_t state;
    // Granted or last served master
    logic   owner;
    logic   req0;
    logic   req1;
    logic   done;
    logic   sel0;
    logic   sel1;

    assign req0 = m0.arvalid | m0.awvalid;
    assign req1 = m1.arvalid | m1.awvalid;
    assign done = (bus.rvalid & bus.rready) | (bus.bvalid & bus.bready);
    assign sel0 = (state == GRANT) & ~owner;
    assign sel1 = (state == GRANT) & owner;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            // m0 wins the first tie
            owner <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (req0 | req1) begin
                        state <= GRANT;
                        owner <= (req0 & req1) ? ~owner : req1;
                    end
                end
                GRANT: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Payload follows the owner while valids need a grant
    assign bus.araddr  = owner ? m1.araddr : m0.araddr;
    assign bus.arvalid = (sel0 & m0.arvalid) | (sel1 & m1.arvalid);
    assign bus.rready  = (sel0 & m0.rready) | (sel1 & m1.rready);
    assign bus.awaddr  = owner ? m1.awaddr : m0.awaddr;
    assign bus.awvalid = (sel0 & m0.awvalid) | (sel1 & m1.awvalid);
    assign bus.wdata   = owner ? m1.wdata : m0.wdata;
    assign bus.wstrb   = owner ? m1.wstrb : m0.wstrb;
    assign bus.wvalid  = (sel0 & m0.wvalid) | (sel1 & m1.wvalid);
    assign bus.bready  = (sel0 & m0.bready) | (sel1 & m1.bready);

    // Readys and valids reach the owner only
    assign m0.arready = sel0 & bus.arready;
    assign m0.rdata   = bus.rdata;
    assign m0.rresp   = bus.rresp;
    assign m0.rvalid  = sel0 & bus.rvalid;
    assign m0.awready = sel0 & bus.awready;
    assign m0.wready  = sel0 & bus.wready;
    assign m0.bresp   = bus.bresp;
    assign m0.bvalid  = sel0 & bus.bvalid;

    assign m1.arready = sel1 & bus.arready;
    assign m1.rdata   = bus.rdata;
    assign m1.rresp   = bus.rresp;
    assign m1.rvalid  = sel1 & bus.rvalid;
    assign m1.awready = sel1 & bus.awready;
    assign m1.wready  = sel1 & bus.wready;
    assign m1.bresp   = bus.bresp;
    assign m1.bvalid  = sel1 & bus.bvalid;

    // A pending request keeps its grant until accepted
    a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr));
    a_aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr));

endmodule

// ==== axil_if.sv ====
`timescale 1ns/1ps

interface axil_if;
    import axil_bus_pkg::*;

    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
    logic       rready;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       wvalid;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

endinterface

// ==== axil_map_pkg.sv ====
`include "axil_soc_config.svh"

package axil_map_pkg;

    typedef logic [$clog2(`AXIL_NUM_SLAVES)-1:0] slave_idx_t;

    // Target of one transaction
    typedef struct packed {
        logic       hit;
        slave_idx_t idx;
    } decode_t;

endpackage

// ==== axil_bus_pkg.sv ====
`include "axil_soc_config.svh"

package axil_bus_pkg;

    typedef logic [`AXIL_ADDR_W-1:0]   axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0]   axil_data_t;
    typedef logic [`AXIL_DATA_W/8-1:0] axil_strb_t;

    // AXI encodings without EXOKAY
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_t;

endpackage

// ==== axil_soc_config.svh ====
`ifndef AXIL_SOC_CONFIG_SVH
`define AXIL_SOC_CONFIG_SVH

// Bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Slaves sit back to back from the base
`define AXIL_NUM_SLAVES 3
`define AXIL_SLAVE_BASE 32'ha000_0000
`define AXIL_SLAVE_SPAN 32'h0000_1000

`define AXIL_RAM_WORDS 64

`endif
